// ==== cpu_mem_if.f ====
+incdir+logic
logic/mem_pkg.sv
logic/loader_rom.sv
logic/block_ram.sv
logic/cache_array.sv
logic/cache_manage_unit.sv
logic/cpu_mem_if.sv
tb/mem_checker.sv
tb/cpu_mem_if_assertions.sv
tb/tb_cpu_mem_if.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_cpu_mem_if
FILELIST  := cpu_mem_if.f
BUILD_DIR := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
LINTFLAGS := --lint-only --timing -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# The log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/cpu_mem_if_testdata.txt ====
# op address wdata be expected
# op F fetch, L load, S store; all numbers hex, expected unused for S
L 00000100 00000000 0 00000000
S 00000104 11223344 f 00000000
S 00000104 aabbccdd 5 00000000
L 00000104 00000000 0 11bb33dd
L 00000900 00000000 0 00000000
L 00000104 00000000 0 11bb33dd
L 00000100 00000000 0 00000000
S 00000230 cafef00d f 00000000
L 00000a30 00000000 0 00000000
L 00000230 00000000 0 cafef00d
S c0000010 deadbeef f 00000000
L c0000010 00000000 0 00000000
S d0000004 12345678 f 00000000
L d0000004 00000000 0 00000000
S e0000000 87654321 3 00000000
L e0000000 00000000 0 00000000
L 00000010 00000000 0 00000000
L 00000004 00000000 0 00000000
F f0000000 00000000 0 b0070000
F f0000004 00000000 0 b0070001
F f000003c 00000000 0 b007000f
F 00000400 00000000 0 00000000
F 00000404 00000000 0 00000000
F 00000400 00000000 0 00000000

// ==== tb/tb_cpu_mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_mem_if;

    localparam int          TIMEOUT_CYCLES = 200;
    localparam int          RESET_CYCLES = 10;
    // Boot ROM address keeps the instruction port quiet
    localparam logic [31:0] QUIET_FETCH = 32'hf000_0000;

    logic                 clk;
    logic                 rst;
    logic [31:0]          instr_addr;
    mem_pkg::cpu_access_t dmem;
    logic [31:0]          instr_data;
    logic [31:0]          dmem_rdata;
    logic                 mem_stall;

    logic                 chk_valid;
    logic [7:0]           chk_op;
    logic [31:0]          chk_addr;
    logic [31:0]          chk_exp;

    int                   check_count;
    int                   error_count;
    int                   timeout_count = 0;
    int                   input_errors = 0;
    int                   access_count = 0;

    cpu_mem_if DUT (
        .clk        (clk),
        .rst        (rst),
        .instr_addr (instr_addr),
        .dmem       (dmem),
        .instr_data (instr_data),
        .dmem_rdata (dmem_rdata),
        .mem_stall  (mem_stall)
    );

    mem_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .mem_stall   (mem_stall),
        .instr_data  (instr_data),
        .dmem_rdata  (dmem_rdata),
        .chk_valid   (chk_valid),
        .chk_op      (chk_op),
        .chk_addr    (chk_addr),
        .chk_exp     (chk_exp),
        .check_count (check_count),
        .error_count (error_count)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic drive_idle();
        dmem = '0;
        instr_addr = QUIET_FETCH;
        chk_valid = 1'b0;
    endtask

    ////////////////////////////////////////
    // One access, held through the stall
    ////////////////////////////////////////
    task automatic run_access(input string op_s, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] be,
                              input logic [31:0] exp);
        int waited;
        waited = 0;
        @(negedge clk);
        drive_idle();
        if (op_s == "F") begin
            instr_addr = addr;
        end else if (op_s == "L") begin
            dmem.rd = 1'b1;
            dmem.addr = addr;
        end else if (op_s == "S") begin
            dmem.wr = 1'b1;
            dmem.addr = addr;
            dmem.wdata = wdata;
            dmem.be = be;
        end
        chk_op = op_s.getc(0);
        chk_addr = addr;
        chk_exp = exp;
        chk_valid = 1'b1;
        access_count++;
        @(posedge clk);
        while (mem_stall && (waited < TIMEOUT_CYCLES)) begin
            waited++;
            @(posedge clk);
        end
        if (mem_stall) begin
            $display("Access %s to %h still stalled after %0d cycles", op_s, addr, waited);
            timeout_count++;
        end
        @(negedge clk);
        drive_idle();
    endtask

    initial begin
        int          fd;
        int          fields;
        int          gap;
        string       line;
        string       op_s;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
        logic [31:0] exp;

        void'($urandom(32'ha21e));
        rst = 1'b1;
        drive_idle();
        chk_op = 8'd0;
        chk_addr = 32'd0;
        chk_exp = 32'd0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fd = $fopen("tb/cpu_mem_if_testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the test data file tb/cpu_mem_if_testdata.txt");
            input_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                fields = $sscanf(line, "%s %h %h %h %h", op_s, addr, wdata, be, exp);
                if ((line.getc(0) != "#") && (fields == 5)) begin
                    if ((op_s != "F") && (op_s != "L") && (op_s != "S")) begin
                        $display("Unknown op %s in the test data", op_s);
                        input_errors++;
                    end else begin
                        gap = $urandom % 4;
                        repeat (gap) @(negedge clk);
                        run_access(op_s, addr, wdata, be, exp);
                    end
                end
            end
            $fclose(fd);
        end

        repeat (2) @(negedge clk);
        $display("Summary: %0d accesses, %0d checks, %0d errors, %0d timeouts, %0d input errors",
                 access_count, check_count, error_count, timeout_count, input_errors);
        if ((error_count == 0) && (timeout_count == 0) && (input_errors == 0)
            && (access_count > 0) && (check_count == access_count)) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/cpu_mem_if_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_mem_if_assertions (
    input logic clk,
    input logic rst,
    input logic mem_en,
    input logic mem_rdy,
    input logic ic_fill,
    input logic dc_fill
);

    // Request outstanding at the block memory
    logic pending_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q <= 1'b0;
        end else if (mem_en) begin
            pending_q <= 1'b1;
        end else if (mem_rdy) begin
            pending_q <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // Controller protocol
    ////////////////////////////////////////
    a_en_single: assert property (@(posedge clk) disable iff (rst) mem_en |=> !mem_en)
        else $error("mem_en high for two cycles in a row");

    a_en_after_rdy: assert property (@(posedge clk) disable iff (rst) mem_en |-> !pending_q)
        else $error("mem_en issued before mem_rdy answered the previous request");

    a_fill_after_rdy: assert property (@(posedge clk) disable iff (rst)
        (ic_fill || dc_fill) |-> $past(mem_rdy))
        else $error("Fill strobe without a preceding mem_rdy");

endmodule

bind cache_manage_unit cpu_mem_if_assertions u_cmu_assertions (
    .clk     (clk),
    .rst     (rst),
    .mem_en  (mem_en),
    .mem_rdy (mem_rdy),
    .ic_fill (ic_fill),
    .dc_fill (dc_fill)
);

`default_nettype wire

// ==== tb/mem_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module mem_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic        mem_stall,
    input  logic [31:0] instr_data,
    input  logic [31:0] dmem_rdata,
    // Access under test, from the driver
    input  logic        chk_valid,
    input  logic [7:0]  chk_op,
    input  logic [31:0] chk_addr,
    input  logic [31:0] chk_exp,
    output int          check_count,
    output int          error_count
);

    int   checks = 0;
    int   errors = 0;
    logic loader_fetch;

    assign check_count = checks;
    assign error_count = errors;

    // Boot ROM fetches must never stall
    assign loader_fetch = chk_valid && (chk_op == "F")
                       && (chk_addr[31:28] == `MEM_REGION_LOADER);

    ////////////////////////////////////////
    // Sampling on the rising edge
    ////////////////////////////////////////
    always @(posedge clk) begin
        if (!rst) begin
            if (!chk_valid && mem_stall) begin
                $display("mem_stall is high while no access is enabled");
                errors++;
            end
            if (loader_fetch && mem_stall) begin
                $display("Loader fetch from %h raised mem_stall", chk_addr);
                errors++;
            end
            // Outputs belong to the access in a cycle without stall
            if (chk_valid && !mem_stall) begin
                checks++;
                if ((chk_op == "L") && (dmem_rdata !== chk_exp)) begin
                    $display("FAILED dmem_rdata addr=%h got=%h exp=%h",
                             chk_addr, dmem_rdata, chk_exp);
                    errors++;
                end else if ((chk_op == "F") && (instr_data !== chk_exp)) begin
                    $display("FAILED instr_data addr=%h got=%h exp=%h",
                             chk_addr, instr_data, chk_exp);
                    errors++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/cpu_mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module cpu_mem_if (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [31:0]          instr_addr,
    input  mem_pkg::cpu_access_t dmem,
    output logic [31:0]          instr_data,
    output logic [31:0]          dmem_rdata,
    output logic                 mem_stall
);

    logic [3:0]           d_region;
    logic                 d_uncached;
    logic                 i_loader;
    mem_pkg::cpu_access_t dc_req;

    logic                 ic_hit;
    logic [31:0]          ic_rdata;
    logic                 ic_fill;
    logic                 dc_hit;
    logic [31:0]          dc_rdata;
    logic                 dc_dirty;
    mem_pkg::mem_laddr_t  dc_victim_addr;
    mem_pkg::mem_line_t   dc_victim_line;
    logic                 dc_fill;
    logic                 dc_store;
    mem_pkg::mem_line_t   fill_line;

    logic                 mem_en;
    logic                 mem_rdy;
    mem_pkg::mem_req_t    mem_req;
    mem_pkg::mem_line_t   mem_rline;
    logic [31:0]          rom_data;

    ////////////////////////////////////////
    // Region decode and port redirects
    ////////////////////////////////////////
    assign d_region = dmem.addr[31:28];
    assign d_uncached = (d_region == `MEM_REGION_VMEM) || (d_region == `MEM_REGION_TIMER)
                     || (d_region == `MEM_REGION_KBD) || (d_region == `MEM_REGION_LOADER);
    assign i_loader = (instr_addr[31:28] == `MEM_REGION_LOADER);

    always_comb begin
        dc_req = dmem;
        dmem_rdata = dc_rdata;
        // Devices not built yet
        if (d_uncached) begin
            dc_req.rd = 1'b0;
            dc_req.wr = 1'b0;
            dmem_rdata = 32'd0;
        end
        instr_data = i_loader ? rom_data : ic_rdata;
    end

    cache_manage_unit u_cmu (
        .clk            (clk),
        .rst            (rst),
        .ic_addr        (instr_addr),
        .ic_cacheable   (~i_loader),
        .ic_hit         (ic_hit),
        .dc_req         (dc_req),
        .dc_hit         (dc_hit),
        .dc_dirty       (dc_dirty),
        .dc_victim_addr (dc_victim_addr),
        .dc_victim_line (dc_victim_line),
        .mem_rdy        (mem_rdy),
        .mem_rline      (mem_rline),
        .mem_en         (mem_en),
        .mem_req        (mem_req),
        .ic_fill        (ic_fill),
        .dc_fill        (dc_fill),
        .fill_line      (fill_line),
        .dc_store       (dc_store),
        .mem_stall      (mem_stall)
    );

    // Instruction side never stores
    cache_array #(.LINES(`MEM_ICACHE_LINES)) u_icache (
        .clk         (clk),
        .rst         (rst),
        .addr        (instr_addr),
        .hit         (ic_hit),
        .rdata       (ic_rdata),
        .dirty       (),
        .victim_addr (),
        .victim_line (),
        .fill        (ic_fill),
        .fill_line   (fill_line),
        .store       (1'b0),
        .wdata       (32'd0),
        .be          (4'd0)
    );

    cache_array #(.LINES(`MEM_DCACHE_LINES)) u_dcache (
        .clk         (clk),
        .rst         (rst),
        .addr        (dc_req.addr),
        .hit         (dc_hit),
        .rdata       (dc_rdata),
        .dirty       (dc_dirty),
        .victim_addr (dc_victim_addr),
        .victim_line (dc_victim_line),
        .fill        (dc_fill),
        .fill_line   (fill_line),
        .store       (dc_store),
        .wdata       (dc_req.wdata),
        .be          (dc_req.be)
    );

    block_ram u_ram (
        .clk       (clk),
        .rst       (rst),
        .mem_en    (mem_en),
        .mem_req   (mem_req),
        .mem_rdy   (mem_rdy),
        .mem_rline (mem_rline)
    );

    loader_rom u_loader (
        .addr (instr_addr[27:2]),
        .data (rom_data)
    );

endmodule

`default_nettype wire

// ==== logic/cache_manage_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module cache_manage_unit (
    input  logic                 clk,
    input  logic                 rst,
    // Instruction cache
    input  logic [31:0]          ic_addr,
    input  logic                 ic_cacheable,
    input  logic                 ic_hit,
    // Data cache
    input  mem_pkg::cpu_access_t dc_req,
    input  logic                 dc_hit,
    input  logic                 dc_dirty,
    input  mem_pkg::mem_laddr_t  dc_victim_addr,
    input  mem_pkg::mem_line_t   dc_victim_line,
    // Block memory
    input  logic                 mem_rdy,
    input  mem_pkg::mem_line_t   mem_rline,
    output logic                 mem_en,
    output mem_pkg::mem_req_t    mem_req,
    // Cache updates
    output logic                 ic_fill,
    output logic                 dc_fill,
    output mem_pkg::mem_line_t   fill_line,
    output logic                 dc_store,
    output logic                 mem_stall
);

    localparam int OFF_W = $clog2(`MEM_LINE_WORDS) + 2;

    mem_pkg::cmu_state_e state_q;
    logic                fill_dc_q;
    logic                dc_miss;
    logic                ic_miss;

    ////////////////////////////////////////
    // Miss detection and stall
    ////////////////////////////////////////
    assign dc_miss = (dc_req.rd | dc_req.wr) & ~dc_hit;
    assign ic_miss = ic_cacheable & ~ic_hit;

    // Held until the refilled line hits
    assign mem_stall = (state_q != mem_pkg::IDLE) | dc_miss | ic_miss;

    // Write hit commits only on a free cycle
    assign dc_store = dc_req.wr & dc_hit & ~mem_stall;

    ////////////////////////////////////////
    // Block memory request
    ////////////////////////////////////////
    assign mem_en = (state_q == mem_pkg::WB_REQ) || (state_q == mem_pkg::FILL_REQ);

    always_comb begin
        mem_req.op = mem_pkg::READ;
        mem_req.wdata = dc_victim_line;
        if (fill_dc_q) begin
            mem_req.addr = dc_req.addr[31:OFF_W];
        end else begin
            mem_req.addr = ic_addr[31:OFF_W];
        end
        // Victim goes out first on a dirty miss
        if (state_q == mem_pkg::WB_REQ) begin
            mem_req.op = mem_pkg::WRITE;
            mem_req.addr = dc_victim_addr;
        end
    end

    ////////////////////////////////////////
    // Miss FSM
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= mem_pkg::IDLE;
            fill_dc_q <= 1'b0;
            ic_fill <= 1'b0;
            dc_fill <= 1'b0;
        end else begin
            ic_fill <= 1'b0;
            dc_fill <= 1'b0;
            case (state_q)
                mem_pkg::IDLE: begin
                    // Data side wins
                    if (dc_miss) begin
                        fill_dc_q <= 1'b1;
                        state_q <= dc_dirty ? mem_pkg::WB_REQ : mem_pkg::FILL_REQ;
                    end else if (ic_miss) begin
                        fill_dc_q <= 1'b0;
                        state_q <= mem_pkg::FILL_REQ;
                    end
                end
                mem_pkg::WB_REQ: begin
                    state_q <= mem_pkg::WB_WAIT;
                end
                mem_pkg::WB_WAIT: begin
                    if (mem_rdy) begin
                        state_q <= mem_pkg::FILL_REQ;
                    end
                end
                mem_pkg::FILL_REQ: begin
                    state_q <= mem_pkg::FILL_WAIT;
                end
                mem_pkg::FILL_WAIT: begin
                    // Leave together with the fill strobe
                    if (mem_rdy) begin
                        dc_fill <= fill_dc_q;
                        ic_fill <= ~fill_dc_q;
                    end else if (ic_fill || dc_fill) begin
                        state_q <= mem_pkg::IDLE;
                    end
                end
                default: begin
                    state_q <= mem_pkg::IDLE;
                end
            endcase
        end
    end

    // Returned line
    always_ff @(posedge clk) begin
        if (mem_rdy && (state_q == mem_pkg::FILL_WAIT)) begin
            fill_line <= mem_rline;
        end
    end

endmodule

`default_nettype wire

// ==== logic/cache_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module cache_array #(
    parameter int LINES = 16
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [31:0]         addr,
    output logic                hit,
    output logic [31:0]         rdata,
    output logic                dirty,
    output mem_pkg::mem_laddr_t victim_addr,
    output mem_pkg::mem_line_t  victim_line,
    input  logic                fill,
    input  mem_pkg::mem_line_t  fill_line,
    input  logic                store,
    input  logic [31:0]         wdata,
    input  logic [3:0]          be
);

    localparam int WOFF_W = $clog2(`MEM_LINE_WORDS);
    localparam int OFF_W = WOFF_W + 2;
    localparam int IDX_W = $clog2(LINES);
    localparam int TAG_W = 32 - OFF_W - IDX_W;

    logic [LINES-1:0]   valid_q;
    logic [LINES-1:0]   dirty_q;
    logic [TAG_W-1:0]   tag_q [LINES];
    mem_pkg::mem_line_t line_q [LINES];

    logic [IDX_W-1:0]   idx;
    logic [TAG_W-1:0]   tag;
    logic [WOFF_W-1:0]  woff;

    ////////////////////////////////////////
    // Address split and lookup
    ////////////////////////////////////////
    assign idx = addr[OFF_W +: IDX_W];
    assign tag = addr[31 -: TAG_W];
    assign woff = addr[2 +: WOFF_W];

    assign hit = valid_q[idx] && (tag_q[idx] == tag);
    assign rdata = line_q[idx][woff];

    // Resident line, for writeback on a miss
    assign dirty = valid_q[idx] & dirty_q[idx];
    assign victim_addr = {tag_q[idx], idx};
    assign victim_line = line_q[idx];

    ////////////////////////////////////////
    // Line state
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill) begin
            // Fresh line from memory is clean
            valid_q[idx] <= 1'b1;
            dirty_q[idx] <= 1'b0;
        end else if (store && hit) begin
            dirty_q[idx] <= 1'b1;
        end
    end

    // Tags and data
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[idx] <= tag;
            line_q[idx] <= fill_line;
        end else if (store && hit) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    line_q[idx][woff][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/block_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module block_ram (
    input  logic               clk,
    input  logic               rst,
    input  logic               mem_en,
    input  mem_pkg::mem_req_t  mem_req,
    output logic               mem_rdy,
    output mem_pkg::mem_line_t mem_rline
);

    localparam int RAM_LINES = `MEM_RAM_WORDS / `MEM_LINE_WORDS;
    localparam int RIDX_W = $clog2(RAM_LINES);
    localparam int CNT_W = $clog2(`MEM_RAM_LATENCY + 1);

    // Main memory starts out cleared
    mem_pkg::mem_line_t ram [RAM_LINES] = '{default: '0};

    mem_pkg::mem_req_t  req_q;
    logic               busy_q;
    logic [CNT_W-1:0]   cnt_q;
    logic               start;
    logic               done;
    logic [RIDX_W-1:0]  ridx;

    assign start = mem_en && !busy_q;
    assign done = busy_q && (cnt_q == CNT_W'(1));

    // Addresses past the array wrap around
    assign ridx = req_q.addr[RIDX_W-1:0];

    ////////////////////////////////////////
    // Latency counter
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            cnt_q <= '0;
            mem_rdy <= 1'b0;
        end else begin
            mem_rdy <= 1'b0;
            if (start) begin
                busy_q <= 1'b1;
                cnt_q <= CNT_W'(`MEM_RAM_LATENCY - 1);
            end else if (done) begin
                busy_q <= 1'b0;
                mem_rdy <= 1'b1;
            end else if (busy_q) begin
                cnt_q <= cnt_q - CNT_W'(1);
            end
        end
    end

    // Request capture and the access itself
    always_ff @(posedge clk) begin
        if (start) begin
            req_q <= mem_req;
        end
        if (done) begin
            if (req_q.op == mem_pkg::WRITE) begin
                ram[ridx] <= req_q.wdata;
            end else begin
                mem_rline <= ram[ridx];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/loader_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module loader_rom (
    input  logic [25:0] addr,
    output logic [31:0] data
);

    localparam int IDX_W = $clog2(`MEM_LOADER_WORDS);

    logic [31:0] rom [`MEM_LOADER_WORDS];
    logic        in_range;

    ////////////////////////////////////////
    // Boot instruction table
    ////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < `MEM_LOADER_WORDS; i++) begin
            rom[i] = 32'hb0070000 + 32'(i);
        end
    end

    // Beyond the table reads as zero
    assign in_range = (addr < 26'(`MEM_LOADER_WORDS));
    assign data = in_range ? rom[addr[IDX_W-1:0]] : 32'd0;

endmodule

`default_nettype wire

// ==== logic/mem_pkg.sv ====
`default_nettype none

`include "mem_macros.svh"

package mem_pkg;

    // One cache line, word 0 in the low bits
    typedef logic [`MEM_LINE_WORDS-1:0][31:0] mem_line_t;

    // Word address divided by the line size
    typedef logic [29-$clog2(`MEM_LINE_WORDS):0] mem_laddr_t;

    typedef enum logic {
        READ,
        WRITE
    } mem_op_e;

    typedef struct packed {
        mem_op_e    op;
        mem_laddr_t addr;
        mem_line_t  wdata;
    } mem_req_t;

    // Miss handling sequence
    typedef enum logic [2:0] {
        IDLE,
        WB_REQ,
        WB_WAIT,
        FILL_REQ,
        FILL_WAIT
    } cmu_state_e;

    // Data port request from the CPU
    typedef struct packed {
        logic        rd;
        logic        wr;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
    } cpu_access_t;

endpackage

`default_nettype wire

// ==== logic/mem_macros.svh ====
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

////////////////////////////////////////
// Cache geometry
////////////////////////////////////////
`define MEM_LINE_WORDS 4
`define MEM_ICACHE_LINES 16
`define MEM_DCACHE_LINES 16

////////////////////////////////////////
// Main memory
////////////////////////////////////////
`define MEM_RAM_WORDS 4096
`define MEM_RAM_LATENCY 6

// Address bits 31:28 of each region
`define MEM_REGION_VMEM 4'hc
`define MEM_REGION_TIMER 4'hd
`define MEM_REGION_KBD 4'he
`define MEM_REGION_LOADER 4'hf

// Boot loader depth in words
`define MEM_LOADER_WORDS 16

`endif
